/* sim.f */
+incdir+testbench
verilog/isaPkg.sv
verilog/controlPkg.sv
verilog/instrDecode.sv
verilog/exceptionUnit.sv
verilog/stateSequencer.sv
verilog/controlWordGen.sv
verilog/multiCycleControl.sv
testbench/tbMultiCycleControl.sv

/* testbench/controlModel.svh */
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// instruction class from the raw fields, unknown encodings are illegal
function automatic instrClassT decodeClass(opcodeT op, functT fn, fmtT fmt);
	instrClassT cls;
	cls = clsIllegal;
	if (op == opRfmt)
	begin
		case (fn)
			fnSll, fnSrl, fnSra:
				cls = clsShift;
			fnMult, fnMultu, fnDiv, fnDivu:
				cls = clsMulDiv;
			fnJr:
				cls = clsJr;
			fnSyscall:
				cls = clsSys;
			fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
			fnXor, fnNor, fnSlt, fnSltu, fnMfhi, fnMflo:
				cls = clsRfmt;
			default:
				cls = clsIllegal;
		endcase
	end
	else if (op == opCop0)
	begin
		// eret is the co form with its own funct
		if (fmt == fmtMtc)
			cls = clsMtc0;
		else if (fmt == fmtMfc)
			cls = clsMfc0;
		else if (fmt == fmtCo && fn == fnEret)
			cls = clsEret;
	end
	else if (op == opAndi || op == opOri || op == opXori)
		cls = clsImmLogic;
	else if (op == opAddi || op == opAddiu || op == opSlti || op == opSltiu || op == opLui)
		cls = clsImmArith;
	else if (op == opLw)
		cls = clsLoad;
	else if (op == opSw)
		cls = clsStore;
	else if (op == opBeq)
		cls = clsBeq;
	else if (op == opBne)
		cls = clsBne;
	else if (op == opJump)
		cls = clsJump;
	else if (op == opJal)
		cls = clsJal;
	return cls;
endfunction

// raw overflow condition, add/sub/addi only
function automatic logic overflowCondition(instrClassT cls, opcodeT op, functT fn,
	logic aluOvf);
	logic checked;
	checked = (cls == clsRfmt && (fn == fnAdd || fn == fnSub)) || (op == opAddi);
	return checked && aluOvf;
endfunction

// cause code by fixed priority
function automatic excCodeT predictCause(instrClassT cls, opcodeT op, logic user,
	logic ovf, logic irq);
	if (cls == clsSys)
		return excSys;
	if (ovf)
		return excAluOvf;
	if (op == opCop0 && user)
		return excInstr;
	if (irq)
		return excInt;
	return excInstr;
endfunction

function automatic logic ownsDelaySlot(instrClassT cls);
	return (cls == clsBeq) || (cls == clsBne) || (cls == clsJump)
		|| (cls == clsJal) || (cls == clsJr);
endfunction

// dispatch out of decode
function automatic ctrlStateT decodeTarget(instrClassT cls, logic user, logic irq);
	case (cls)
		clsRfmt, clsMulDiv:
			return stRfmt;
		clsShift:
			return stShift;
		clsImmLogic:
			return stIfmtL;
		clsImmArith:
			return stIfmtA;
		clsLoad, clsStore:
			return stLwSw;
		// control flow diverts on a pending interrupt
		clsBeq:
			return irq ? stCop0Exc : stBeq;
		clsBne:
			return irq ? stCop0Exc : stBne;
		clsJump:
			return irq ? stCop0Exc : stJump;
		clsJal:
			return irq ? stCop0Exc : stJal;
		clsJr:
			return irq ? stCop0Exc : stJr;
		clsSys:
			return user ? stCop0Exc : stFetch;
		// privileged in user mode
		clsMtc0:
			return user ? stCop0Exc : stCop0Mtc0;
		clsMfc0:
			return user ? stCop0Exc : stCop0Mfc0;
		clsEret:
			return user ? stCop0Exc : stCop0Eret;
		default:
			return stCop0Exc;
	endcase
endfunction

function automatic ctrlStateT predictNextState(ctrlStateT st, instrClassT cls,
	logic user, logic irq, logic trap);
	case (st)
		stFetch:
			return stDecode;
		stDecode:
			return decodeTarget(cls, user, irq);
		stLwSw:
			return (cls == clsStore) ? stSw : stLw;
		stLw:
			return stLw2;
		stLw2, stSw:
			return irq ? stCop0Exc : stFetch;
		// mult/div finish after one execute step
		stRfmt:
			return (cls == clsMulDiv) ? stFetch : stRfmt2;
		stShift:
			return stRfmt2;
		stIfmtL, stIfmtA:
			return stIfmt2;
		stRfmt2, stIfmt2:
			return (trap || irq) ? stCop0Exc : stFetch;
		default:
			return stFetch;
	endcase
endfunction

// memory is read in fetch and in the load access step
function automatic logic readsMemory(ctrlStateT st);
	return (st == stFetch) || (st == stLw);
endfunction

function automatic logic writesRegister(ctrlStateT st);
	return (st == stLw2) || (st == stRfmt2) || (st == stIfmt2)
		|| (st == stJal) || (st == stCop0Mfc0);
endfunction

function automatic logic writesPc(ctrlStateT st);
	return (st == stFetch) || (st == stJump) || (st == stJal)
		|| (st == stJr) || (st == stCop0Eret) || (st == stCop0Exc);
endfunction

// pc mux, branches take the target computed in decode
function automatic pcSourceT nextPcSource(ctrlStateT st);
	case (st)
		stBeq, stBne:
			return pcAluOut;
		stJump, stJal:
			return pcJumpTarget;
		stJr:
			return pcRegister;
		stCop0Eret:
			return pcEpc;
		stCop0Exc:
			return pcExcVector;
		default:
			return pcAluResult;
	endcase
endfunction

function automatic aluOpT aluControl(ctrlStateT st);
	case (st)
		stRfmt, stShift:
			return aluFunct;
		stIfmtL, stIfmtA, stJal:
			return aluOpcode;
		// branches compare by subtraction
		stBeq, stBne:
			return aluSub;
		default:
			return aluAdd;
	endcase
endfunction

function automatic aluSrcAT operandA(ctrlStateT st);
	case (st)
		stLwSw, stRfmt, stIfmtL, stIfmtA, stBeq, stBne:
			return srcARegA;
		stShift:
			return srcAShamt;
		default:
			return srcAPc;
	endcase
endfunction

function automatic aluSrcBT operandB(ctrlStateT st);
	case (st)
		stFetch:
			return srcBFour;
		stDecode:
			return srcBBranchOff;
		stLwSw, stIfmtA:
			return srcBSignImm;
		// logic immediates are zero extended
		stIfmtL:
			return srcBZeroImm;
		stJal:
			return srcBLink;
		default:
			return srcBRegB;
	endcase
endfunction

function automatic storeSelT writebackSelect(ctrlStateT st);
	case (st)
		stJal:
			return storeLink;
		stCop0Mfc0:
			return storeCop0;
		default:
			return storeRegular;
	endcase
endfunction

`endif

/* testbench/tbMultiCycleControl.sv */
`timescale 1ns/1ps

module tbMultiCycleControl
	import isaPkg::*;
	import controlPkg::*;
();

	localparam int pIrqWidth = 8;
	localparam int pInstrCount = 3000;
	localparam int pTimeout = 20;

	logic iCLK;
	logic iRST;
	opcodeT iOp;
	functT iFunct;
	fmtT iFmt;
	logic iAluOverflow;
	logic iUserMode;
	logic iExcLevel;
	logic [pIrqWidth-1:0] iPendingInterrupt;
	logic oIRWrite;
	logic oMemtoReg;
	logic oMemWrite;
	logic oMemRead;
	logic oIorD;
	logic oPCWrite;
	logic oPCWriteBEQ;
	logic oPCWriteBNE;
	logic oRegWrite;
	logic oRegDst;
	logic oCop0RegWrite;
	logic oCop0Eret;
	logic oExcOccurred;
	logic oPcOriginalWrite;
	pcSourceT oPCSource;
	aluOpT oALUOp;
	aluSrcAT oALUSrcA;
	aluSrcBT oALUSrcB;
	storeSelT oStore;
	ctrlStateT oState;
	excCodeT oExcCode;
	logic oBranchDelay;
	logic oInterrupted;

	// model state, advanced at each falling edge
	ctrlStateT modelState;
	bit resetPending;
	functT aluFuncts [12] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
		fnXor, fnNor, fnSlt, fnSltu, fnMfhi, fnMflo};

	multiCycleControl #(.pIrqWidth(pIrqWidth)) dut (.*);

	`include "controlModel.svh"

	initial
	begin
		iCLK = 1'b0;
		forever #2 iCLK = ~iCLK;
	end

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compareState(string name, ctrlStateT got, ctrlStateT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch at %0t: %s is %s, expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic compareCode(string name, excCodeT got, excCodeT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
				$time, name, got, exp));
	endtask

	task automatic compareBit(string name, logic got, logic exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch at %0t: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic comparePcSource(string name, pcSourceT got, pcSourceT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch at %0t: %s is %s, expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic compareAluOp(string name, aluOpT got, aluOpT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch at %0t: %s is %s, expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic compareSrcA(string name, aluSrcAT got, aluSrcAT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch at %0t: %s is %s, expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic compareSrcB(string name, aluSrcBT got, aluSrcBT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch at %0t: %s is %s, expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic compareStore(string name, storeSelT got, storeSelT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch at %0t: %s is %s, expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	// new instruction fields, weighted toward the kept encodings
	task automatic driveFields();
		int pick;
		opcodeT op;
		functT fn;
		fmtT fmt;
		pick = $urandom % 100;
		// random background, the tail of the range keeps it as is
		op = opcodeT'($urandom);
		fn = functT'($urandom);
		fmt = fmtT'($urandom);
		if (pick < 20)
		begin
			op = opRfmt;
			fn = aluFuncts[$urandom % 12];
		end
		else if (pick < 26)
		begin
			op = opRfmt;
			fn = ($urandom % 3 == 0) ? fnSll : (($urandom % 2 == 0) ? fnSrl : fnSra);
		end
		else if (pick < 30)
		begin
			op = opRfmt;
			fn = functT'(fnMult + ($urandom % 4));
		end
		else if (pick < 34)
		begin
			op = opRfmt;
			fn = fnJr;
		end
		else if (pick < 39)
		begin
			op = opRfmt;
			fn = fnSyscall;
		end
		else if (pick < 46)
			op = opcodeT'(opAndi + ($urandom % 3));
		else if (pick < 54)
			op = opcodeT'(opAddi + ($urandom % 4)) | (($urandom % 5 == 0) ? opLui : 6'h00);
		else if (pick < 61)
			op = opLw;
		else if (pick < 67)
			op = opSw;
		else if (pick < 72)
			op = opBeq;
		else if (pick < 77)
			op = opBne;
		else if (pick < 81)
			op = opJump;
		else if (pick < 85)
			op = opJal;
		else if (pick < 94)
		begin
			op = opCop0;
			fmt = (pick < 88) ? fmtMtc : ((pick < 91) ? fmtMfc : fmtCo);
			if (pick >= 91)
				fn = fnEret;
		end
		iOp <= op;
		iFunct <= fn;
		iFmt <= fmt;
	endtask

	// level inputs change every cycle
	task automatic randomizeLevels();
		iAluOverflow <= ($urandom % 4) == 0;
		iUserMode <= ($urandom % 2) == 1;
		iExcLevel <= ($urandom % 4) == 0;
		if ($urandom % 6 == 0)
			iPendingInterrupt <= pIrqWidth'(1) << ($urandom % pIrqWidth);
		else
			iPendingInterrupt <= '0;
	endtask

	task automatic confirmReset();
		compareState("oState", oState, stFetch);
		compareBit("oIRWrite", oIRWrite, 1'b1);
		compareBit("oMemRead", oMemRead, 1'b1);
		compareBit("oPCWrite", oPCWrite, 1'b1);
		compareBit("oMemWrite", oMemWrite, 1'b0);
		compareBit("oRegWrite", oRegWrite, 1'b0);
	endtask

	// all checks of one cycle, sampled at the falling edge
	task automatic evaluateCycle(output ctrlStateT nextExp);
		instrClassT cls;
		logic irq;
		logic ovf;
		excCodeT cause;
		cls = decodeClass(iOp, iFunct, iFmt);
		irq = (|iPendingInterrupt) && !iExcLevel;
		ovf = overflowCondition(cls, iOp, iFunct, iAluOverflow);
		cause = predictCause(cls, iOp, iUserMode, ovf, irq);
		compareState("oState", oState, modelState);
		compareBit("oIRWrite", oIRWrite, modelState == stFetch);
		compareBit("oMemRead", oMemRead, readsMemory(modelState));
		compareBit("oMemWrite", oMemWrite, modelState == stSw);
		compareBit("oRegWrite", oRegWrite, writesRegister(modelState));
		compareBit("oPCWrite", oPCWrite, writesPc(modelState));
		compareBit("oMemtoReg", oMemtoReg, modelState == stLw2);
		compareBit("oIorD", oIorD, (modelState == stLw) || (modelState == stSw));
		compareBit("oPCWriteBEQ", oPCWriteBEQ, modelState == stBeq);
		compareBit("oPCWriteBNE", oPCWriteBNE, modelState == stBne);
		compareBit("oRegDst", oRegDst, modelState == stRfmt2);
		compareBit("oPcOriginalWrite", oPcOriginalWrite, modelState != stCop0Exc);
		comparePcSource("oPCSource", oPCSource, nextPcSource(modelState));
		compareAluOp("oALUOp", oALUOp, aluControl(modelState));
		compareSrcA("oALUSrcA", oALUSrcA, operandA(modelState));
		compareSrcB("oALUSrcB", oALUSrcB, operandB(modelState));
		compareStore("oStore", oStore, writebackSelect(modelState));
		compareBit("oCop0RegWrite", oCop0RegWrite, modelState == stCop0Mtc0);
		compareBit("oCop0Eret", oCop0Eret, modelState == stCop0Eret);
		compareBit("oExcOccurred", oExcOccurred, modelState == stCop0Exc);
		compareBit("oBranchDelay", oBranchDelay, ownsDelaySlot(cls));
		compareBit("oInterrupted", oInterrupted,
			(modelState == stCop0Exc) && (cause == excInt));
		if (modelState == stDecode)
			compareCode("oExcCode", oExcCode, cause);
		// trap needs the level low, the cause code does not
		nextExp = predictNextState(modelState, cls, iUserMode, irq, ovf && !iExcLevel);
	endtask

	// one instruction from fetch back to fetch
	task automatic runInstruction(int index);
		int cycles;
		bit done;
		ctrlStateT nextExp;
		cycles = 0;
		done = 1'b0;
		while (!done)
		begin
			@(negedge iCLK);
			if (resetPending)
			begin
				confirmReset();
				resetPending = 1'b0;
			end
			evaluateCycle(nextExp);
			modelState = nextExp;
			done = (nextExp == stFetch);
			cycles++;
			if (!done && cycles >= pTimeout)
				abortRun($sformatf("instruction %0d did not return to fetch within %0d cycles",
					index, pTimeout));
			@(posedge iCLK);
			// fields only move as fetch begins
			if (done)
				driveFields();
			randomizeLevels();
		end
	endtask

	initial
	begin
		iRST = 1'b1;
		iOp = opRfmt;
		iFunct = fnSll;
		iFmt = fmtMfc;
		iAluOverflow = 1'b0;
		iUserMode = 1'b0;
		iExcLevel = 1'b0;
		iPendingInterrupt = '0;
		modelState = stFetch;
		resetPending = 1'b1;
		void'($urandom(32'hcb6b));
		repeat (8) @(posedge iCLK);
		iRST <= 1'b0;
		driveFields();
		randomizeLevels();
		for (int i = 0; i < pInstrCount; i++)
			runInstruction(i);
		$display("TEST PASS");
		$finish;
	end

endmodule

/* verilog/multiCycleControl.sv */
`timescale 1ns/1ps

module multiCycleControl
	import isaPkg::*;
	import controlPkg::*;
#(
	parameter int pIrqWidth = 8
)
(
	input logic iCLK,
	input logic iRST,
	input opcodeT iOp,
	input functT iFunct,
	input fmtT iFmt,
	input logic iAluOverflow,
	input logic iUserMode,
	input logic iExcLevel,
	input logic [pIrqWidth-1:0] iPendingInterrupt,
	output logic oIRWrite,
	output logic oMemtoReg,
	output logic oMemWrite,
	output logic oMemRead,
	output logic oIorD,
	output logic oPCWrite,
	output logic oPCWriteBEQ,
	output logic oPCWriteBNE,
	output logic oRegWrite,
	output logic oRegDst,
	output logic oCop0RegWrite,
	output logic oCop0Eret,
	output logic oExcOccurred,
	output logic oPcOriginalWrite,
	output pcSourceT oPCSource,
	output aluOpT oALUOp,
	output aluSrcAT oALUSrcA,
	output aluSrcBT oALUSrcB,
	output storeSelT oStore,
	output ctrlStateT oState,
	output excCodeT oExcCode,
	output logic oBranchDelay,
	output logic oInterrupted
);

	instrClassT instrClass;
	logic irqPending;
	logic ovfTrap;
	ctrlStateT presentState;

	instrDecode uDecode
	(
		.iOp(iOp),
		.iFunct(iFunct),
		.iFmt(iFmt),
		.instrClass(instrClass),
		.branchDelay(oBranchDelay)
	);

	exceptionUnit #(.pIrqWidth(pIrqWidth)) uException
	(
		.instrClass(instrClass),
		.iFunct(iFunct),
		.iOp(iOp),
		.iAluOverflow(iAluOverflow),
		.iExcLevel(iExcLevel),
		.iUserMode(iUserMode),
		.iPendingInterrupt(iPendingInterrupt),
		.irqPending(irqPending),
		.ovfTrap(ovfTrap),
		.excCode(oExcCode)
	);

	stateSequencer uSequencer
	(
		.iCLK(iCLK),
		.iRST(iRST),
		.instrClass(instrClass),
		.iUserMode(iUserMode),
		.irqPending(irqPending),
		.ovfTrap(ovfTrap),
		.presentState(presentState)
	);

	controlWordGen uWordGen
	(
		.presentState(presentState),
		.oIRWrite(oIRWrite),
		.oMemtoReg(oMemtoReg),
		.oMemWrite(oMemWrite),
		.oMemRead(oMemRead),
		.oIorD(oIorD),
		.oPCWrite(oPCWrite),
		.oPCWriteBEQ(oPCWriteBEQ),
		.oPCWriteBNE(oPCWriteBNE),
		.oRegWrite(oRegWrite),
		.oRegDst(oRegDst),
		.oCop0RegWrite(oCop0RegWrite),
		.oCop0Eret(oCop0Eret),
		.oExcOccurred(oExcOccurred),
		.oPcOriginalWrite(oPcOriginalWrite),
		.oPCSource(oPCSource),
		.oALUOp(oALUOp),
		.oALUSrcA(oALUSrcA),
		.oALUSrcB(oALUSrcB),
		.oStore(oStore),
		.oState(oState)
	);

	// flags an interrupt entry so cop0 can tell it from a synchronous trap
	assign oInterrupted = (presentState == stCop0Exc) && (oExcCode == excInt);

endmodule

/* verilog/controlWordGen.sv */
`timescale 1ns/1ps

module controlWordGen
	import controlPkg::*;
(
	input ctrlStateT presentState,
	output logic oIRWrite,
	output logic oMemtoReg,
	output logic oMemWrite,
	output logic oMemRead,
	output logic oIorD,
	output logic oPCWrite,
	output logic oPCWriteBEQ,
	output logic oPCWriteBNE,
	output logic oRegWrite,
	output logic oRegDst,
	output logic oCop0RegWrite,
	output logic oCop0Eret,
	output logic oExcOccurred,
	output logic oPcOriginalWrite,
	output pcSourceT oPCSource,
	output aluOpT oALUOp,
	output aluSrcAT oALUSrcA,
	output aluSrcBT oALUSrcB,
	output storeSelT oStore,
	output ctrlStateT oState
);

	// per-state datapath strobes
	always_comb
	begin
		oIRWrite = 1'b0;
		oMemtoReg = 1'b0;
		oMemWrite = 1'b0;
		oMemRead = 1'b0;
		oIorD = 1'b0;
		oPCWrite = 1'b0;
		oPCWriteBEQ = 1'b0;
		oPCWriteBNE = 1'b0;
		oRegWrite = 1'b0;
		oRegDst = 1'b0;
		oPCSource = pcAluResult;
		oALUOp = aluAdd;
		oALUSrcA = srcAPc;
		oALUSrcB = srcBRegB;
		oStore = storeRegular;
		case (presentState)
			// ir <= mem[pc], pc <= pc + 4
			stFetch:
			begin
				oMemRead = 1'b1;
				oIRWrite = 1'b1;
				oPCWrite = 1'b1;
				oALUSrcB = srcBFour;
			end
			// branch target precomputed while registers are read
			stDecode:
				oALUSrcB = srcBBranchOff;
			stLwSw:
			begin
				oALUSrcA = srcARegA;
				oALUSrcB = srcBSignImm;
			end
			stLw:
			begin
				oIorD = 1'b1;
				oMemRead = 1'b1;
			end
			stLw2:
			begin
				oMemtoReg = 1'b1;
				oRegWrite = 1'b1;
			end
			stSw:
			begin
				oIorD = 1'b1;
				oMemWrite = 1'b1;
			end
			stRfmt:
			begin
				oALUOp = aluFunct;
				oALUSrcA = srcARegA;
			end
			// shamt replaces rs on the a side
			stShift:
			begin
				oALUOp = aluFunct;
				oALUSrcA = srcAShamt;
			end
			stRfmt2:
			begin
				oRegWrite = 1'b1;
				oRegDst = 1'b1;
			end
			stIfmtL:
			begin
				oALUOp = aluOpcode;
				oALUSrcA = srcARegA;
				oALUSrcB = srcBZeroImm;
			end
			stIfmtA:
			begin
				oALUOp = aluOpcode;
				oALUSrcA = srcARegA;
				oALUSrcB = srcBSignImm;
			end
			stIfmt2:
				oRegWrite = 1'b1;
			// compare by subtraction, zero flag qualifies the pc write
			stBeq, stBne:
			begin
				oPCWriteBEQ = (presentState == stBeq);
				oPCWriteBNE = (presentState == stBne);
				oPCSource = pcAluOut;
				oALUOp = aluSub;
				oALUSrcA = srcARegA;
			end
			stJump:
			begin
				oPCWrite = 1'b1;
				oPCSource = pcJumpTarget;
			end
			// link address goes to ra through the link store path
			stJal:
			begin
				oPCWrite = 1'b1;
				oPCSource = pcJumpTarget;
				oALUOp = aluOpcode;
				oALUSrcB = srcBLink;
				oRegWrite = 1'b1;
				oStore = storeLink;
			end
			stJr:
			begin
				oPCWrite = 1'b1;
				oPCSource = pcRegister;
			end
			stCop0Mfc0:
			begin
				oRegWrite = 1'b1;
				oStore = storeCop0;
			end
			stCop0Eret:
			begin
				oPCWrite = 1'b1;
				oPCSource = pcEpc;
			end
			stCop0Exc:
			begin
				oPCWrite = 1'b1;
				oPCSource = pcExcVector;
			end
			default:
				oPCSource = pcAluResult;
		endcase
	end

	// coprocessor 0 strobes
	assign oCop0RegWrite = (presentState == stCop0Mtc0);
	assign oCop0Eret = (presentState == stCop0Eret);
	assign oExcOccurred = (presentState == stCop0Exc);
	// epc keeps tracking the pc except on exception entry
	assign oPcOriginalWrite = (presentState != stCop0Exc);
	assign oState = presentState;

	// the memory port is single ported
	always_comb
	begin
		assert final (!(oMemRead && oMemWrite));
	end

endmodule

/* verilog/stateSequencer.sv */
`timescale 1ns/1ps

module stateSequencer
	import controlPkg::*;
(
	input logic iCLK,
	input logic iRST,
	input instrClassT instrClass,
	input logic iUserMode,
	input logic irqPending,
	input logic ovfTrap,
	output ctrlStateT presentState
);

	ctrlStateT nextState;

	// state register
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			presentState <= stFetch;
		else
			presentState <= nextState;
	end

	// next-state logic
	always_comb
	begin
		nextState = stFetch;
		case (presentState)
			stFetch:
				nextState = stDecode;
			stDecode:
				case (instrClass)
					clsRfmt, clsMulDiv:
						nextState = stRfmt;
					clsShift:
						nextState = stShift;
					clsImmLogic:
						nextState = stIfmtL;
					clsImmArith:
						nextState = stIfmtA;
					clsLoad, clsStore:
						nextState = stLwSw;
					// control flow takes a pending interrupt before it moves the pc
					clsJr:
						nextState = irqPending ? stCop0Exc : stJr;
					clsJump:
						nextState = irqPending ? stCop0Exc : stJump;
					clsBeq:
						nextState = irqPending ? stCop0Exc : stBeq;
					clsBne:
						nextState = irqPending ? stCop0Exc : stBne;
					clsJal:
						nextState = irqPending ? stCop0Exc : stJal;
					// syscall is a no-op in kernel mode
					clsSys:
						nextState = iUserMode ? stCop0Exc : stFetch;
					// privileged cop0 access
					clsMtc0:
						nextState = iUserMode ? stCop0Exc : stCop0Mtc0;
					clsMfc0:
						nextState = iUserMode ? stCop0Exc : stCop0Mfc0;
					clsEret:
						nextState = iUserMode ? stCop0Exc : stCop0Eret;
					default:
						nextState = stCop0Exc;
				endcase
			// address computed, split on direction
			stLwSw:
				nextState = (instrClass == clsStore) ? stSw : stLw;
			stLw:
				nextState = stLw2;
			stLw2, stSw:
				nextState = irqPending ? stCop0Exc : stFetch;
			stRfmt:
				nextState = (instrClass == clsMulDiv) ? stFetch : stRfmt2;
			stShift:
				nextState = stRfmt2;
			stIfmtL, stIfmtA:
				nextState = stIfmt2;
			// writeback states trap on overflow as well
			stRfmt2, stIfmt2:
				nextState = (ovfTrap || irqPending) ? stCop0Exc : stFetch;
			stBeq, stBne, stJump, stJal, stJr:
				nextState = stFetch;
			stCop0Mtc0, stCop0Mfc0, stCop0Eret, stCop0Exc:
				nextState = stFetch;
			// illegal encodings recover through fetch
			default:
				nextState = stFetch;
		endcase
	end

	// reset always lands in fetch
	assert property (@(posedge iCLK) iRST |=> presentState == stFetch);

endmodule

/* verilog/exceptionUnit.sv */
`timescale 1ns/1ps

module exceptionUnit
	import isaPkg::*;
	import controlPkg::*;
#(
	parameter int pIrqWidth = 8
)
(
	input instrClassT instrClass,
	input functT iFunct,
	input opcodeT iOp,
	input logic iAluOverflow,
	input logic iExcLevel,
	input logic iUserMode,
	input logic [pIrqWidth-1:0] iPendingInterrupt,
	output logic irqPending,
	output logic ovfTrap,
	output excCodeT excCode
);

	logic ovfCheck;
	logic ovfCond;

	// interrupts are masked while the handler runs
	assign irqPending = (|iPendingInterrupt) && !iExcLevel;

	// only the signed add/sub forms raise overflow
	assign ovfCheck = ((instrClass == clsRfmt) && (iFunct == fnAdd || iFunct == fnSub))
		|| (iOp == opAddi);
	assign ovfCond = ovfCheck && iAluOverflow;

	// a trap is taken only outside exception level
	assign ovfTrap = ovfCond && !iExcLevel;

	// cause code priority
	always_comb
	begin
		if (instrClass == clsSys)
			excCode = excSys;
		else if (ovfCond)
			excCode = excAluOvf;
		// cop0 access from user mode is reported as a reserved instruction
		else if (iOp == opCop0 && iUserMode)
			excCode = excInstr;
		else if (irqPending)
			excCode = excInt;
		else
			excCode = excInstr;
	end

endmodule

/* verilog/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode
	import isaPkg::*;
	import controlPkg::*;
(
	input opcodeT iOp,
	input functT iFunct,
	input fmtT iFmt,
	output instrClassT instrClass,
	output logic branchDelay
);

	// one class per instruction, anything unlisted is illegal
	always_comb
	begin
		instrClass = clsIllegal;
		case (iOp)
			opRfmt:
				case (iFunct)
					fnAdd, fnAddu, fnSub, fnSubu,
					fnAnd, fnOr, fnXor, fnNor,
					fnSlt, fnSltu, fnMfhi, fnMflo:
						instrClass = clsRfmt;
					fnSll, fnSrl, fnSra:
						instrClass = clsShift;
					// hi/lo units run on their own after the first execute step
					fnMult, fnMultu, fnDiv, fnDivu:
						instrClass = clsMulDiv;
					fnJr:
						instrClass = clsJr;
					fnSyscall:
						instrClass = clsSys;
					default:
						instrClass = clsIllegal;
				endcase
			opAndi, opOri, opXori:
				instrClass = clsImmLogic;
			opAddi, opAddiu, opSlti, opSltiu, opLui:
				instrClass = clsImmArith;
			opLw:
				instrClass = clsLoad;
			opSw:
				instrClass = clsStore;
			opBeq:
				instrClass = clsBeq;
			opBne:
				instrClass = clsBne;
			opJump:
				instrClass = clsJump;
			opJal:
				instrClass = clsJal;
			opCop0:
				case (iFmt)
					fmtMtc:
						instrClass = clsMtc0;
					fmtMfc:
						instrClass = clsMfc0;
					// eret also needs its funct, other co encodings are reserved
					fmtCo:
						instrClass = (iFunct == fnEret) ? clsEret : clsIllegal;
					default:
						instrClass = clsIllegal;
				endcase
			default:
				instrClass = clsIllegal;
		endcase
	end

	// instructions that own a delay slot, reported to cop0 for epc fixup
	assign branchDelay = instrClass inside {clsBeq, clsBne, clsJump, clsJal, clsJr};

	// x fields from the instruction register still fall into the illegal class
	always_comb
	begin
		assert final (!$isunknown(instrClass));
	end

endmodule

/* verilog/controlPkg.sv */
package controlPkg;

	// fsm states of the multicycle sequence
	typedef enum logic [5:0]
	{
		stFetch = 6'd0,
		stDecode = 6'd1,
		// memory path
		stLwSw = 6'd2,
		stLw = 6'd3,
		stLw2 = 6'd4,
		stSw = 6'd5,
		// alu path
		stRfmt = 6'd6,
		stRfmt2 = 6'd7,
		stShift = 6'd8,
		stIfmtL = 6'd9,
		stIfmtA = 6'd10,
		stIfmt2 = 6'd11,
		// control flow
		stBeq = 6'd12,
		stBne = 6'd13,
		stJump = 6'd14,
		stJal = 6'd15,
		stJr = 6'd16,
		// coprocessor 0
		stCop0Mtc0 = 6'd17,
		stCop0Mfc0 = 6'd18,
		stCop0Eret = 6'd19,
		stCop0Exc = 6'd20
	} ctrlStateT;

	// instruction class produced by the decoder
	typedef enum logic [4:0]
	{
		clsRfmt, clsShift, clsMulDiv, clsJr, clsSys,
		clsImmLogic, clsImmArith, clsLoad, clsStore,
		clsBeq, clsBne, clsJump, clsJal,
		clsMtc0, clsMfc0, clsEret, clsIllegal
	} instrClassT;

	// next pc source mux
	typedef enum logic [2:0]
	{
		pcAluResult = 3'd0,
		pcAluOut = 3'd1,
		pcJumpTarget = 3'd2,
		pcRegister = 3'd3,
		pcExcVector = 3'd4,
		pcEpc = 3'd5
	} pcSourceT;

	// alu control, 2 and 3 defer to funct and opcode
	typedef enum logic [1:0]
	{
		aluAdd = 2'd0,
		aluSub = 2'd1,
		aluFunct = 2'd2,
		aluOpcode = 2'd3
	} aluOpT;

	typedef enum logic [1:0]
	{
		srcAPc = 2'd0,
		srcARegA = 2'd1,
		srcAShamt = 2'd2
	} aluSrcAT;

	typedef enum logic [2:0]
	{
		srcBRegB = 3'd0,
		srcBFour = 3'd1,
		srcBSignImm = 3'd2,
		srcBBranchOff = 3'd3,
		srcBZeroImm = 3'd4,
		srcBLink = 3'd5
	} aluSrcBT;

	// register file write data, regular path picks alu or memory by MemtoReg
	typedef enum logic [2:0]
	{
		storeRegular = 3'd0,
		storeLink = 3'd1,
		storeCop0 = 3'd6
	} storeSelT;

endpackage

/* verilog/isaPkg.sv */
package isaPkg;

	// raw instruction fields as seen at the instruction register
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;
	typedef logic [4:0] fmtT;

	// cause code written into the coprocessor 0 cause register
	typedef logic [4:0] excCodeT;

	// primary opcodes
	localparam opcodeT opRfmt  = 6'h00;
	localparam opcodeT opJump  = 6'h02;
	localparam opcodeT opJal   = 6'h03;
	localparam opcodeT opBeq   = 6'h04;
	localparam opcodeT opBne   = 6'h05;
	localparam opcodeT opAddi  = 6'h08;
	localparam opcodeT opAddiu = 6'h09;
	localparam opcodeT opSlti  = 6'h0a;
	localparam opcodeT opSltiu = 6'h0b;
	localparam opcodeT opAndi  = 6'h0c;
	localparam opcodeT opOri   = 6'h0d;
	localparam opcodeT opXori  = 6'h0e;
	localparam opcodeT opLui   = 6'h0f;
	localparam opcodeT opCop0  = 6'h10;
	localparam opcodeT opLw    = 6'h23;
	localparam opcodeT opSw    = 6'h2b;

	// funct field of the r-format opcode
	localparam functT fnSll = 6'h00;
	localparam functT fnSrl = 6'h02;
	localparam functT fnSra = 6'h03;
	localparam functT fnJr = 6'h08;
	localparam functT fnSyscall = 6'h0c;
	localparam functT fnMfhi = 6'h10;
	localparam functT fnMflo = 6'h12;
	localparam functT fnMult = 6'h18;
	localparam functT fnMultu = 6'h19;
	localparam functT fnDiv = 6'h1a;
	localparam functT fnDivu = 6'h1b;
	localparam functT fnAdd = 6'h20;
	localparam functT fnAddu = 6'h21;
	localparam functT fnSub = 6'h22;
	localparam functT fnSubu = 6'h23;
	localparam functT fnAnd = 6'h24;
	localparam functT fnOr = 6'h25;
	localparam functT fnXor = 6'h26;
	localparam functT fnNor = 6'h27;
	localparam functT fnSlt = 6'h2a;
	localparam functT fnSltu = 6'h2b;
	// eret shares the funct slot of mult but lives under the cop0 opcode
	localparam functT fnEret = 6'h18;

	// rs/fmt field of cop0 instructions
	localparam fmtT fmtMfc = 5'h00;
	localparam fmtT fmtMtc = 5'h04;
	localparam fmtT fmtCo = 5'h10;

	// cause codes
	localparam excCodeT excInt = 5'd0;
	localparam excCodeT excSys = 5'd8;
	localparam excCodeT excInstr = 5'd10;
	localparam excCodeT excAluOvf = 5'd12;

endpackage
